// File: rtl/nixie_pkg.sv
package nixie_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Build constants
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Dwell counter reload, one phase lasts SCAN_DIV+1 idle cycles
	localparam int SCAN_DIV = 7;

	// Counter wide enough to hold SCAN_DIV
	localparam int CTR_W = (SCAN_DIV > 0) ? $clog2(SCAN_DIV + 1) : 1;

	localparam int NUM_BANKS = 2; // Multiplexed banks sharing one phase
	localparam int DIGITS = 4; // Digits per bank, also the phase width

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus word views
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Address 0 sees the word as bank values, address 1 as the single register
	typedef union packed {
		logic [NUM_BANKS-1:0][15:0] banks; // Bank 1 in the upper half
		struct packed {
			logic [23:0] pad; // Reads back as zero
			logic [7:0] value;
		} single;
	} nixie_word_u;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Segment decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Active high, bit 0 is segment a up to bit 6 for segment g
	// Decimal point in bit 7 stays dark
	function automatic logic [7:0] hex_segments(input logic [3:0] value);
		logic [7:0] seg;
		case (value)
			4'h0: seg = 8'h3f;
			4'h1: seg = 8'h06;
			4'h2: seg = 8'h5b;
			4'h3: seg = 8'h4f;
			4'h4: seg = 8'h66;
			4'h5: seg = 8'h6d;
			4'h6: seg = 8'h7d;
			4'h7: seg = 8'h07;
			4'h8: seg = 8'h7f;
			4'h9: seg = 8'h6f;
			4'ha: seg = 8'h77;
			4'hb: seg = 8'h7c; // Lower case b
			4'hc: seg = 8'h39;
			4'hd: seg = 8'h5e; // Lower case d
			4'he: seg = 8'h79;
			default: seg = 8'h71; // F
		endcase
		return seg;
	endfunction

endpackage

// File: rtl/nixie_regs.sv
module nixie_regs (
	input logic clk,
	input logic rst,

	input logic addr,
	input logic write_enable,
	input logic [31:0] write_data,
	output logic [31:0] read_result,

	output logic [nixie_pkg::NUM_BANKS-1:0][15:0] bank_values,
	output logic [3:0] single_digit
);

	nixie_pkg::nixie_word_u wr_word; // Incoming bus word
	nixie_pkg::nixie_word_u rd_word; // Outgoing readback word

	logic [nixie_pkg::NUM_BANKS-1:0][15:0] bank_q;
	logic [7:0] single_q;

	assign wr_word = write_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			bank_q <= '0;
			single_q <= '0;
		end else if (write_enable) begin
			if (addr == 1'b0) begin
				bank_q <= wr_word.banks; // Both banks at once
			end else begin
				single_q <= wr_word.single.value;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Readback
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		rd_word = '0;
		if (addr == 1'b0) begin
			rd_word.banks = bank_q;
		end else begin
			rd_word.single.value = single_q; // Upper bits stay zero
		end
	end

	assign read_result = rd_word;

	assign bank_values = bank_q;
	assign single_digit = single_q[3:0]; // Only the low nibble is shown

endmodule

// File: rtl/nixie_scan_timer.sv
module nixie_scan_timer (
	input logic clk,
	input logic rst,

	input logic hold, // Bus write in progress
	output logic [nixie_pkg::DIGITS-1:0] phase
);

	logic [nixie_pkg::CTR_W-1:0] ctr;
	logic [nixie_pkg::DIGITS-1:0] next_phase;
	logic phase_legal;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase rotation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Exactly one bit set
	assign phase_legal = (phase != '0) && ((phase & (phase - 1'b1)) == '0);

	always_comb begin
		if (phase_legal) begin
			next_phase = {phase[0], phase[nixie_pkg::DIGITS-1:1]}; // 1000 -> 0100 ...
		end else begin
			// Reset value 1111 and anything odd restart at the leftmost digit
			next_phase = '0;
			next_phase[nixie_pkg::DIGITS-1] = 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Dwell counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			ctr <= '0; // Zero so the first idle cycle advances
			phase <= '1; // All digits lit during reset recovery
		end else if (!hold) begin
			if (ctr != '0) begin
				ctr <= ctr - 1'b1;
			end else begin
				ctr <= nixie_pkg::CTR_W'(nixie_pkg::SCAN_DIV);
				phase <= next_phase;
			end
		end
		// Writes freeze counter and phase
	end

endmodule

// File: rtl/nixie_bank.sv
module nixie_bank (
	input logic [nixie_pkg::DIGITS-1:0] phase,
	input logic [15:0] bank_value,
	output logic [7:0] segments
);

	logic [3:0] nibble;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Digit select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Phase bit i picks nibble i, so 1000 shows bits 15:12
	always_comb begin
		nibble = bank_value[3:0]; // Fallback for 1111 and other non one-hot values
		for (int i = 1; i < nixie_pkg::DIGITS; i++) begin
			if (phase == (nixie_pkg::DIGITS'(1) << i)) begin
				nibble = bank_value[4*i +: 4];
			end
		end
	end

	assign segments = nixie_pkg::hex_segments(nibble);

endmodule

// File: rtl/nixie_pin_stage.sv
module nixie_pin_stage (
	input logic clk,
	input logic rst,

	input logic [nixie_pkg::DIGITS-1:0] phase,
	input logic [nixie_pkg::NUM_BANKS-1:0][7:0] bank_segments,
	input logic [3:0] single_digit,

	output logic [7:0] digital_tube0,
	output logic [7:0] digital_tube1,
	output logic [7:0] digital_tube2,
	output logic [3:0] digital_tube_sel0,
	output logic [3:0] digital_tube_sel1
);

	logic [7:0] single_segments;

	// Static digit has no select, just a decoder
	assign single_segments = nixie_pkg::hex_segments(single_digit);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pin registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Segments and selects move on the same edge, no ghosting between digits
	always_ff @(posedge clk) begin
		if (rst) begin
			digital_tube0 <= '0; // Dark
			digital_tube1 <= '0;
			digital_tube2 <= '0;
			digital_tube_sel0 <= '0; // No digit selected
			digital_tube_sel1 <= '0;
		end else begin
			digital_tube0 <= bank_segments[0];
			digital_tube1 <= bank_segments[1];
			digital_tube2 <= single_segments;
			digital_tube_sel0 <= phase;
			digital_tube_sel1 <= phase; // Both banks scan together
		end
	end

endmodule

// File: rtl/nixie_display.sv
module nixie_display (
	input logic clk,
	input logic rst,

	// CPU bus
	input logic addr,
	input logic write_enable,
	input logic [31:0] write_data,
	output logic [31:0] read_result,

	// Board pins
	output logic [7:0] digital_tube0,
	output logic [7:0] digital_tube1,
	output logic [7:0] digital_tube2,
	output logic [3:0] digital_tube_sel0,
	output logic [3:0] digital_tube_sel1
);

	logic [nixie_pkg::NUM_BANKS-1:0][15:0] bank_values;
	logic [nixie_pkg::NUM_BANKS-1:0][7:0] bank_segments;
	logic [3:0] single_digit;
	logic [nixie_pkg::DIGITS-1:0] phase;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registers and scan timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	nixie_regs regs_inst (
		.clk (clk),
		.rst (rst),
		.addr (addr),
		.write_enable (write_enable),
		.write_data (write_data),
		.read_result (read_result),
		.bank_values (bank_values),
		.single_digit (single_digit)
	);

	// Scan pauses while the CPU writes
	nixie_scan_timer scan_timer_inst (
		.clk (clk),
		.rst (rst),
		.hold (write_enable),
		.phase (phase)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Multiplexed banks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar b = 0; b < nixie_pkg::NUM_BANKS; b++) begin : g_bank
		nixie_bank bank_inst (
			.phase (phase),
			.bank_value (bank_values[b]),
			.segments (bank_segments[b])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Board pins
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	nixie_pin_stage pin_stage_inst (
		.clk (clk),
		.rst (rst),
		.phase (phase),
		.bank_segments (bank_segments),
		.single_digit (single_digit),
		.digital_tube0 (digital_tube0),
		.digital_tube1 (digital_tube1),
		.digital_tube2 (digital_tube2),
		.digital_tube_sel0 (digital_tube_sel0),
		.digital_tube_sel1 (digital_tube_sel1)
	);

endmodule

// File: bench/nixie_display_checker.sv
module nixie_display_checker (
	input logic clk,
	input logic rst,
	input logic [7:0] digital_tube0,
	input logic [7:0] digital_tube1,
	input logic [7:0] digital_tube2,
	input logic [3:0] digital_tube_sel0,
	input logic [3:0] digital_tube_sel1
);

	int unsigned failures = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pin invariants
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Dark, all lit after reset, or one digit
	sel_legal: assert property (@(posedge clk) disable iff (rst)
		(digital_tube_sel0 == 4'b1111) || $onehot0(digital_tube_sel0))
		else begin
			failures++;
			$error("Illegal select value %b", digital_tube_sel0);
		end

	sel_equal: assert property (@(posedge clk) disable iff (rst)
		digital_tube_sel0 == digital_tube_sel1)
		else begin
			failures++;
			$error("Select pins differ, %b and %b", digital_tube_sel0, digital_tube_sel1);
		end

	dp_dark: assert property (@(posedge clk) disable iff (rst)
		!digital_tube0[7] && !digital_tube1[7] && !digital_tube2[7])
		else begin
			failures++;
			$error("Decimal point lit");
		end

	// All pin registers clear one cycle into reset
	reset_dark: assert property (@(posedge clk) rst |=>
		(digital_tube0 == '0) && (digital_tube1 == '0) && (digital_tube2 == '0) &&
		(digital_tube_sel0 == '0) && (digital_tube_sel1 == '0))
		else begin
			failures++;
			$error("Pins not cleared after reset");
		end

endmodule

bind nixie_display nixie_display_checker checker_inst (
	.clk (clk),
	.rst (rst),
	.digital_tube0 (digital_tube0),
	.digital_tube1 (digital_tube1),
	.digital_tube2 (digital_tube2),
	.digital_tube_sel0 (digital_tube_sel0),
	.digital_tube_sel1 (digital_tube_sel1)
);

// File: bench/nixie_display_tb.sv
module nixie_display_tb;

	localparam int DWELL = nixie_pkg::SCAN_DIV + 1; // Idle cycles per digit
	localparam int SEL_TIMEOUT = 4 * DWELL + 16;
	localparam int BURST_LEN = 3;

	logic clk;
	logic rst;
	logic addr;
	logic write_enable;
	logic [31:0] write_data;
	logic [31:0] read_result;
	logic [7:0] digital_tube0;
	logic [7:0] digital_tube1;
	logic [7:0] digital_tube2;
	logic [3:0] digital_tube_sel0;
	logic [3:0] digital_tube_sel1;

	logic [31:0] rng_state;
	logic [31:0] shadow_banks; // Bank 1 in the upper half
	logic [7:0] shadow_single;
	logic [7:0] seg_table [16];

	nixie_display nixie_display_inst (
		.clk (clk),
		.rst (rst),
		.addr (addr),
		.write_enable (write_enable),
		.write_data (write_data),
		.read_result (read_result),
		.digital_tube0 (digital_tube0),
		.digital_tube1 (digital_tube1),
		.digital_tube2 (digital_tube2),
		.digital_tube_sel0 (digital_tube_sel0),
		.digital_tube_sel1 (digital_tube_sel1)
	);

	always #20 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Digit shown for a select value with 1111 falling back to the low nibble
	function automatic logic [3:0] shown_nibble(input logic [3:0] sel, input logic [15:0] value);
		logic [3:0] nib;
		case (sel)
			4'b1000: nib = value[15:12];
			4'b0100: nib = value[11:8];
			4'b0010: nib = value[7:4];
			default: nib = value[3:0];
		endcase
		return nib;
	endfunction

	function automatic logic [31:0] expected_read(input logic a);
		return a ? {24'h0, shadow_single} : shadow_banks;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		stop_on_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus and pin helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic write_reg(input logic a, input logic [31:0] d);
		@(posedge clk);
		addr <= a;
		write_enable <= 1'b1;
		write_data <= d;
		@(posedge clk);
		write_enable <= 1'b0;
		if (a == 1'b0) begin
			shadow_banks = d;
		end else begin
			shadow_single = d[7:0];
		end
		@(negedge clk); // New value already visible
		assert (read_result == expected_read(a))
			else report_mismatch("read_result after write", read_result, expected_read(a));
	endtask

	task automatic read_reg(input logic a, output logic [31:0] d);
		@(posedge clk);
		addr <= a;
		@(negedge clk);
		d = read_result;
	endtask

	task automatic compare_segments();
		logic [7:0] exp0;
		logic [7:0] exp1;
		logic [7:0] exp2;
		exp0 = seg_table[shown_nibble(digital_tube_sel0, shadow_banks[15:0])];
		exp1 = seg_table[shown_nibble(digital_tube_sel1, shadow_banks[31:16])];
		exp2 = seg_table[shadow_single[3:0]];
		assert (digital_tube0 == exp0) else report_mismatch("digital_tube0", digital_tube0, exp0);
		assert (digital_tube1 == exp1) else report_mismatch("digital_tube1", digital_tube1, exp1);
		assert (digital_tube2 == exp2) else report_mismatch("digital_tube2", digital_tube2, exp2);
	endtask

	// Counts negedges until the select moves on
	task automatic next_select(output int cycles);
		logic [3:0] start;
		start = digital_tube_sel0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > SEL_TIMEOUT) begin
				stop_on_error($sformatf("Timeout: digital_tube_sel0 never changed from %b", start));
			end
		end while (digital_tube_sel0 == start);
	endtask

	task automatic wait_for_select(input logic [3:0] value);
		int cycles;
		cycles = 0;
		while (digital_tube_sel0 !== value) begin
			@(negedge clk);
			cycles++;
			if (cycles > SEL_TIMEOUT) begin
				stop_on_error($sformatf("Timeout: digital_tube_sel0 never changed to %b", value));
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic reset_state();
		logic [31:0] data;
		wait_for_select(4'b1111);
		compare_segments(); // Cleared registers show 0
		wait_for_select(4'b1000);
		read_reg(1'b0, data);
		assert (data == 32'h0) else report_mismatch("address 0 after reset", data, 32'h0);
		read_reg(1'b1, data);
		assert (data == 32'h0) else report_mismatch("address 1 after reset", data, 32'h0);
	endtask

	task automatic register_readback();
		logic [31:0] word;
		logic [31:0] data;
		for (int i = 0; i < 4; i++) begin
			word = next_random();
			write_reg(1'b0, word);
			read_reg(1'b1, data);
			assert (data == {24'h0, shadow_single})
				else report_mismatch("address 1 after address 0 write", data, {24'h0, shadow_single});
			word = next_random();
			write_reg(1'b1, word);
			read_reg(1'b0, data);
			assert (data == shadow_banks)
				else report_mismatch("address 0 after address 1 write", data, shadow_banks);
			read_reg(1'b1, data);
			assert (data == {24'h0, word[7:0]})
				else report_mismatch("address 1 readback", data, {24'h0, word[7:0]});
		end
	endtask

	task automatic scan_order_and_dwell();
		logic [3:0] order [4];
		int cycles;
		order = '{4'b0100, 4'b0010, 4'b0001, 4'b1000};
		next_select(cycles); // Align to a digit boundary
		for (int i = 0; i < 4 && digital_tube_sel0 != 4'b1000; i++) begin
			next_select(cycles);
		end
		assert (digital_tube_sel0 == 4'b1000)
			else report_mismatch("digital_tube_sel0 at scan start", digital_tube_sel0, 4'b1000);
		for (int i = 0; i < 4; i++) begin
			next_select(cycles);
			assert (digital_tube_sel0 == order[i])
				else report_mismatch("digital_tube_sel0", digital_tube_sel0, order[i]);
			assert (cycles == DWELL) else report_mismatch("digit dwell", cycles, DWELL);
			compare_segments();
		end
	endtask

	task automatic segment_content();
		int cycles;
		for (int round = 0; round < 3; round++) begin
			write_reg(1'b0, next_random());
			write_reg(1'b1, next_random());
			next_select(cycles);
			for (int i = 0; i < 2 * nixie_pkg::DIGITS; i++) begin
				next_select(cycles);
				assert (cycles == DWELL) else report_mismatch("digit dwell", cycles, DWELL);
				compare_segments();
			end
		end
	endtask

	task automatic write_freeze();
		logic [3:0] held;
		logic [31:0] word;
		int cycles;
		int rest;
		next_select(rest);
		held = digital_tube_sel0;
		cycles = 0;
		repeat (2) begin
			@(negedge clk);
			cycles++;
		end
		for (int k = 0; k < BURST_LEN; k++) begin
			word = next_random();
			@(posedge clk);
			addr <= 1'b0;
			write_enable <= 1'b1;
			write_data <= word;
			shadow_banks = word;
			@(negedge clk);
			cycles++;
			assert (digital_tube_sel0 == held)
				else report_mismatch("digital_tube_sel0 during writes", digital_tube_sel0, held);
		end
		@(posedge clk);
		write_enable <= 1'b0;
		@(negedge clk);
		cycles++;
		next_select(rest);
		cycles += rest;
		assert (cycles == DWELL + BURST_LEN)
			else report_mismatch("dwell with write burst", cycles, DWELL + BURST_LEN);
		compare_segments(); // Last burst word on the next digit
	endtask

	always @(nixie_display_inst.checker_inst.failures) begin
		assert (nixie_display_inst.checker_inst.failures == 0)
			else stop_on_error("A bound pin assertion failed");
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		addr = 1'b0;
		write_enable = 1'b0;
		write_data = '0;
		rng_state = 32'h5a5444f2;
		shadow_banks = '0;
		shadow_single = '0;
		// Hex shapes 0-9, A, b, C, d, E, F
		seg_table = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
			8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		reset_state();
		register_readback();
		scan_order_and_dwell();
		segment_content();
		write_freeze();

		if (nixie_display_inst.checker_inst.failures != 0) begin
			$display("Bound pin assertions failed %0d times",
				nixie_display_inst.checker_inst.failures);
			$display("*** TEST FAILED ***");
			$fatal(1, "Pin assertions reported errors");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// File: nixie_display.f
rtl/nixie_pkg.sv
rtl/nixie_regs.sv
rtl/nixie_scan_timer.sv
rtl/nixie_bank.sv
rtl/nixie_pin_stage.sv
rtl/nixie_display.sv
bench/nixie_display_checker.sv
bench/nixie_display_tb.sv

// File: Bender.yml
package:
  name: nixie_display

sources:
  # Design, package first
  - rtl/nixie_pkg.sv
  - rtl/nixie_regs.sv
  - rtl/nixie_scan_timer.sv
  - rtl/nixie_bank.sv
  - rtl/nixie_pin_stage.sv
  - rtl/nixie_display.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - bench/nixie_display_checker.sv
      - bench/nixie_display_tb.sv
